/* include/vanilla_sb_defines.svh */
`ifndef VANILLA_SB_DEFINES_SVH
`define VANILLA_SB_DEFINES_SVH

// region encodings, matched against the top bits of the effective address
// dram is top bit 1
`define sb_region_dram 1'b1
// global is top bits 01
`define sb_region_global 2'b01
// group is top bits 001
`define sb_region_group 3'b001

// pending bit positions within one scoreboard entry
`define sb_bit_long 2'd3
`define sb_bit_dram 2'd2
`define sb_bit_global 2'd1
`define sb_bit_group 2'd0

`endif

/* rtl/vanilla_sb_pkg.sv */
package vanilla_sb_pkg;

  // datapath and register file sizes
  localparam int data_width = 32;
  localparam int reg_addr_width = 5;
  localparam int reg_els = 32;
  localparam int imm_width = 12;

  // pending bits kept per register
  localparam int sb_bits = 4;

  // iteration counter width of the divider
  localparam int div_cnt_width = $clog2(data_width);

  typedef logic [data_width-1:0] data_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [sb_bits-1:0] sb_entry_t;
  typedef logic [imm_width-1:0] imm_t;

  // index of one pending bit inside an entry
  typedef logic [$clog2(sb_bits)-1:0] sb_bit_t;

  // class of the op sitting in the issue slot
  typedef enum logic [2:0] {
    op_alu,
    op_load,
    op_amo,
    op_flw,
    op_idiv,
    op_fdiv,
    op_fsqrt,
    op_nop
  } op_class_e;

  typedef enum logic [1:0] {
    div_idle,
    div_busy,
    div_done
  } div_state_e;

endpackage

/* rtl/sb_set_if.sv */
`timescale 1ns/1ps

// one scoreboard set request per issued instruction
interface sb_set_if;
  import vanilla_sb_pkg::*;

  logic      set_valid;
  logic      set_float;
  reg_addr_t set_rd;
  sb_bit_t   set_bit;

  modport decoder (
    output set_valid,
    output set_float,
    output set_rd,
    output set_bit
  );

  modport tracker (
    input set_valid,
    input set_float,
    input set_rd,
    input set_bit
  );

endinterface

/* rtl/remote_region_decoder.sv */
`timescale 1ns/1ps
`include "vanilla_sb_defines.svh"

module remote_region_decoder (
  input  logic                      id_issue,
  input  vanilla_sb_pkg::op_class_e id_op,
  input  vanilla_sb_pkg::reg_addr_t id_rd,
  input  vanilla_sb_pkg::data_t     id_rs1_val,
  input  vanilla_sb_pkg::imm_t      id_imm,
  output logic                      req_valid,
  output logic                      req_float,
  output vanilla_sb_pkg::reg_addr_t req_rd,
  output vanilla_sb_pkg::data_t     req_addr,
  sb_set_if.decoder                 sb_set
);
  import vanilla_sb_pkg::*;

  data_t   eff_addr;
  logic    in_dram;
  logic    in_global;
  logic    in_group;
  logic    int_mem_op;
  logic    float_mem_op;
  logic    long_op;
  logic    float_dest;
  logic    mem_remote;
  sb_bit_t set_bit;

  // rs1 plus sign-extended immediate
  assign eff_addr = id_rs1_val + {{(data_width-imm_width){id_imm[imm_width-1]}}, id_imm};

  // regions are disjoint, anything else is local memory
  assign in_dram = (eff_addr[data_width-1] == `sb_region_dram);
  assign in_global = (eff_addr[data_width-1 -: 2] == `sb_region_global);
  assign in_group = (eff_addr[data_width-1 -: 3] == `sb_region_group);

  assign int_mem_op = (id_op == op_load) || (id_op == op_amo);
  assign float_mem_op = (id_op == op_flw);
  assign long_op = (id_op == op_idiv) || (id_op == op_fdiv) || (id_op == op_fsqrt);
  assign float_dest = float_mem_op || (id_op == op_fdiv) || (id_op == op_fsqrt);
  assign mem_remote = (int_mem_op | float_mem_op) & (in_dram | in_global | in_group);

  // remote request leaves in the issue cycle
  assign req_valid = id_issue & mem_remote;
  assign req_float = float_mem_op;
  assign req_rd = id_rd;
  assign req_addr = eff_addr;

  // long-latency first, then dram, global, group
  always_comb begin
    if (long_op) begin
      set_bit = `sb_bit_long;
    end else if (in_dram) begin
      set_bit = `sb_bit_dram;
    end else if (in_global) begin
      set_bit = `sb_bit_global;
    end else begin
      set_bit = `sb_bit_group;
    end
  end

  // int x0 is never tracked
  assign sb_set.set_valid = id_issue & (long_op | mem_remote) & (float_dest | (id_rd != '0));
  assign sb_set.set_float = float_dest;
  assign sb_set.set_rd = id_rd;
  assign sb_set.set_bit = set_bit;

endmodule

/* rtl/scoreboard_tracker.sv */
`timescale 1ns/1ps

module scoreboard_tracker (
  input  logic                      clk_i,
  input  logic                      reset_i,
  sb_set_if.tracker                 sb_set,
  input  logic                      resp_valid,
  input  logic                      resp_float,
  input  vanilla_sb_pkg::reg_addr_t resp_rd,
  input  logic                      div_done,
  input  vanilla_sb_pkg::reg_addr_t div_rd,
  input  logic                      fpu_done,
  input  vanilla_sb_pkg::reg_addr_t fpu_done_rd,
  output vanilla_sb_pkg::sb_entry_t [vanilla_sb_pkg::reg_els-1:0] int_sb,
  output vanilla_sb_pkg::sb_entry_t [vanilla_sb_pkg::reg_els-1:0] float_sb,
  output logic                      div_ack
);
  import vanilla_sb_pkg::*;

  sb_entry_t [reg_els-1:0] int_sb_r;
  sb_entry_t [reg_els-1:0] float_sb_r;

  logic      int_resp;
  logic      float_resp;
  logic      int_clear;
  logic      float_clear;
  reg_addr_t int_clear_rd;
  reg_addr_t float_clear_rd;

  assign int_resp = resp_valid & ~resp_float;
  assign float_resp = resp_valid & resp_float;

  // response beats the divider, the divider holds its result
  assign div_ack = div_done & ~int_resp;

  assign int_clear = int_resp | div_done;
  assign int_clear_rd = int_resp ? resp_rd : div_rd;

  // a colliding fpu_done is simply lost
  assign float_clear = float_resp | fpu_done;
  assign float_clear_rd = float_resp ? resp_rd : fpu_done_rd;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      int_sb_r <= '0;
      float_sb_r <= '0;
    end else begin
      if (sb_set.set_valid) begin
        if (sb_set.set_float) begin
          float_sb_r[sb_set.set_rd][sb_set.set_bit] <= 1'b1;
        end else begin
          int_sb_r[sb_set.set_rd][sb_set.set_bit] <= 1'b1;
        end
      end

      // clears come last so they override a set to the same register
      if (int_clear) begin
        int_sb_r[int_clear_rd] <= '0;
      end
      if (float_clear) begin
        float_sb_r[float_clear_rd] <= '0;
      end
    end
  end

  assign int_sb = int_sb_r;
  assign float_sb = float_sb_r;

endmodule

/* rtl/hazard_check.sv */
`timescale 1ns/1ps

module hazard_check (
  input  logic                      id_valid,
  input  vanilla_sb_pkg::op_class_e id_op,
  input  vanilla_sb_pkg::reg_addr_t id_rd,
  input  vanilla_sb_pkg::reg_addr_t id_rs1,
  input  vanilla_sb_pkg::reg_addr_t id_rs2,
  input  vanilla_sb_pkg::sb_entry_t [vanilla_sb_pkg::reg_els-1:0] int_sb,
  input  vanilla_sb_pkg::sb_entry_t [vanilla_sb_pkg::reg_els-1:0] float_sb,
  input  logic                      div_busy,
  output logic                      stall
);
  import vanilla_sb_pkg::*;

  logic rs1_int;
  logic rs2_int;
  logic rd_int;
  logic rs1_float;
  logic rs2_float;
  logic rd_float;
  logic int_hit;
  logic float_hit;

  // which file each operand lives in
  always_comb begin
    rs1_int = 1'b0;
    rs2_int = 1'b0;
    rd_int = 1'b0;
    rs1_float = 1'b0;
    rs2_float = 1'b0;
    rd_float = 1'b0;
    unique case (id_op)
      op_alu, op_amo, op_idiv: begin
        rs1_int = 1'b1;
        rs2_int = 1'b1;
        rd_int = 1'b1;
      end
      op_load: begin
        rs1_int = 1'b1;
        rd_int = 1'b1;
      end
      op_flw: begin
        rs1_int = 1'b1;
        rd_float = 1'b1;
      end
      op_fdiv: begin
        rs1_float = 1'b1;
        rs2_float = 1'b1;
        rd_float = 1'b1;
      end
      op_fsqrt: begin
        rs1_float = 1'b1;
        rd_float = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // int x0 never counts as pending
  assign int_hit = (rs1_int & (id_rs1 != '0) & (int_sb[id_rs1] != '0))
                 | (rs2_int & (id_rs2 != '0) & (int_sb[id_rs2] != '0))
                 | (rd_int & (id_rd != '0) & (int_sb[id_rd] != '0));

  assign float_hit = (rs1_float & (float_sb[id_rs1] != '0))
                   | (rs2_float & (float_sb[id_rs2] != '0))
                   | (rd_float & (float_sb[id_rd] != '0));

  assign stall = id_valid & (int_hit | float_hit | ((id_op == op_idiv) & div_busy));

endmodule

/* rtl/idiv_unit.sv */
`timescale 1ns/1ps

module idiv_unit (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      start,
  input  vanilla_sb_pkg::reg_addr_t start_rd,
  input  vanilla_sb_pkg::data_t     dividend,
  input  vanilla_sb_pkg::data_t     divisor,
  input  logic                      ack,
  output logic                      busy,
  output logic                      done,
  output vanilla_sb_pkg::reg_addr_t done_rd,
  output vanilla_sb_pkg::data_t     quotient
);
  import vanilla_sb_pkg::*;

  div_state_e               state_r;
  logic [div_cnt_width-1:0] cnt_r;

  // partial remainder, shifting quotient and operand
  data_t     rem_r;
  data_t     quot_r;
  data_t     divisor_r;
  reg_addr_t rd_r;

  logic [data_width:0] rem_shift;
  logic [data_width:0] diff;
  logic                sub_ok;

  assign rem_shift = {rem_r, quot_r[data_width-1]};
  assign diff = rem_shift - {1'b0, divisor_r};
  // zero divisor always subtracts, so the quotient ends all ones
  assign sub_ok = ~diff[data_width];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= div_idle;
      cnt_r <= '0;
    end else begin
      unique case (state_r)
        div_idle: begin
          if (start) begin
            state_r <= div_busy;
            cnt_r <= '0;
          end
        end
        div_busy: begin
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == '1) begin
            state_r <= div_done;
          end
        end
        div_done: begin
          if (ack) begin
            state_r <= div_idle;
          end
        end
        default: begin
          state_r <= div_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == div_idle) && start) begin
      rem_r <= '0;
      quot_r <= dividend;
      divisor_r <= divisor;
      rd_r <= start_rd;
    end else if (state_r == div_busy) begin
      // one quotient bit per cycle, msb first
      rem_r <= sub_ok ? diff[data_width-1:0] : rem_shift[data_width-1:0];
      quot_r <= {quot_r[data_width-2:0], sub_ok};
    end
  end

  assign busy = (state_r != div_idle);
  assign done = (state_r == div_done);
  assign done_rd = rd_r;
  assign quotient = quot_r;

endmodule

/* rtl/vanilla_sb_top.sv */
`timescale 1ns/1ps

module vanilla_sb_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      flush_i,
  input  logic                      id_valid_i,
  input  vanilla_sb_pkg::op_class_e id_op_i,
  input  vanilla_sb_pkg::reg_addr_t id_rd_i,
  input  vanilla_sb_pkg::reg_addr_t id_rs1_i,
  input  vanilla_sb_pkg::reg_addr_t id_rs2_i,
  input  vanilla_sb_pkg::data_t     id_rs1_val_i,
  input  vanilla_sb_pkg::data_t     id_rs2_val_i,
  input  vanilla_sb_pkg::imm_t      id_imm_i,
  input  logic                      resp_valid_i,
  input  logic                      resp_float_i,
  input  vanilla_sb_pkg::reg_addr_t resp_rd_i,
  input  logic                      fpu_done_i,
  input  vanilla_sb_pkg::reg_addr_t fpu_done_rd_i,
  output logic                      stall_o,
  output logic                      remote_req_valid_o,
  output logic                      remote_req_float_o,
  output vanilla_sb_pkg::reg_addr_t remote_req_rd_o,
  output vanilla_sb_pkg::data_t     remote_req_addr_o,
  output logic                      div_wb_valid_o,
  output vanilla_sb_pkg::reg_addr_t div_wb_rd_o,
  output vanilla_sb_pkg::data_t     div_wb_quot_o,
  output vanilla_sb_pkg::sb_entry_t [vanilla_sb_pkg::reg_els-1:0] int_sb_o,
  output vanilla_sb_pkg::sb_entry_t [vanilla_sb_pkg::reg_els-1:0] float_sb_o
);
  import vanilla_sb_pkg::*;

  logic div_busy;
  logic div_ack;

  // the slot issues when valid, not flushed and not stalled
  wire id_issue = id_valid_i & ~flush_i & ~stall_o;
  wire div_start = id_issue & (id_op_i == op_idiv);

  sb_set_if set_bus ();

  remote_region_decoder decoder_i (
    .id_issue   (id_issue),
    .id_op      (id_op_i),
    .id_rd      (id_rd_i),
    .id_rs1_val (id_rs1_val_i),
    .id_imm     (id_imm_i),
    .req_valid  (remote_req_valid_o),
    .req_float  (remote_req_float_o),
    .req_rd     (remote_req_rd_o),
    .req_addr   (remote_req_addr_o),
    .sb_set     (set_bus.decoder)
  );

  scoreboard_tracker tracker_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .sb_set      (set_bus.tracker),
    .resp_valid  (resp_valid_i),
    .resp_float  (resp_float_i),
    .resp_rd     (resp_rd_i),
    .div_done    (div_wb_valid_o),
    .div_rd      (div_wb_rd_o),
    .fpu_done    (fpu_done_i),
    .fpu_done_rd (fpu_done_rd_i),
    .int_sb      (int_sb_o),
    .float_sb    (float_sb_o),
    .div_ack     (div_ack)
  );

  hazard_check hazard_i (
    .id_valid (id_valid_i),
    .id_op    (id_op_i),
    .id_rd    (id_rd_i),
    .id_rs1   (id_rs1_i),
    .id_rs2   (id_rs2_i),
    .int_sb   (int_sb_o),
    .float_sb (float_sb_o),
    .div_busy (div_busy),
    .stall    (stall_o)
  );

  idiv_unit idiv_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start    (div_start),
    .start_rd (id_rd_i),
    .dividend (id_rs1_val_i),
    .divisor  (id_rs2_val_i),
    .ack      (div_ack),
    .busy     (div_busy),
    .done     (div_wb_valid_o),
    .done_rd  (div_wb_rd_o),
    .quotient (div_wb_quot_o)
  );

endmodule

/* verif/vanilla_sb_assertions.sv */
`timescale 1ns/1ps

module vanilla_sb_assertions (
  input logic clk_i,
  input logic reset_i,
  input logic resp_valid,
  input logic resp_float,
  input logic div_done,
  input vanilla_sb_pkg::sb_entry_t [vanilla_sb_pkg::reg_els-1:0] int_sb,
  input vanilla_sb_pkg::sb_entry_t [vanilla_sb_pkg::reg_els-1:0] float_sb
);
  import vanilla_sb_pkg::*;

  logic one_bit_ok;

  // a register takes a set only while idle, so one bit at most
  always_comb begin
    one_bit_ok = 1'b1;
    for (int r = 0; r < reg_els; r++) begin
      if (!$onehot0(int_sb[r]) || !$onehot0(float_sb[r])) begin
        one_bit_ok = 1'b0;
      end
    end
  end

  x0_never_pending: assert property (@(posedge clk_i) disable iff (reset_i) int_sb[0] == '0)
    else $error("int register 0 is marked pending");

  single_bit_per_entry: assert property (@(posedge clk_i) disable iff (reset_i) one_bit_ok)
    else $error("scoreboard entry holds more than one pending bit");

  // an integer response leaves the divider result waiting
  int_resp_holds_div: assert property (@(posedge clk_i) disable iff (reset_i)
    (div_done && resp_valid && !resp_float) |=> div_done)
    else $error("divider acknowledged in a cycle with an integer response");

endmodule

bind scoreboard_tracker vanilla_sb_assertions sb_assertions_i (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .resp_valid (resp_valid),
  .resp_float (resp_float),
  .div_done   (div_done),
  .int_sb     (int_sb),
  .float_sb   (float_sb)
);

/* verif/tb_vanilla_sb.sv */
`timescale 1ns/1ps

module tb_vanilla_sb;
  import vanilla_sb_pkg::*;

  logic clk_i;
  logic reset_i;
  logic flush_i;
  logic id_valid_i;
  op_class_e id_op_i;
  reg_addr_t id_rd_i;
  reg_addr_t id_rs1_i;
  reg_addr_t id_rs2_i;
  reg_addr_t resp_rd_i;
  reg_addr_t fpu_done_rd_i;
  data_t id_rs1_val_i;
  data_t id_rs2_val_i;
  imm_t id_imm_i;
  logic resp_valid_i;
  logic resp_float_i;
  logic fpu_done_i;
  logic stall_o;
  logic remote_req_valid_o;
  logic remote_req_float_o;
  logic div_wb_valid_o;
  reg_addr_t remote_req_rd_o;
  reg_addr_t div_wb_rd_o;
  data_t remote_req_addr_o;
  data_t div_wb_quot_o;
  sb_entry_t [reg_els-1:0] int_sb_o;
  sb_entry_t [reg_els-1:0] float_sb_o;

  // expected scoreboards and pending divider result
  sb_entry_t exp_int [reg_els];
  sb_entry_t exp_float [reg_els];
  data_t exp_quot;
  reg_addr_t exp_div_rd;

  logic [15:0] lfsr;
  string cur_test;
  int err_cnt;
  int test_err;
  int test_cnt;

  vanilla_sb_top dut_i (.*);

  always #4 clk_i = ~clk_i;

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output data_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[data_width-2:0], lfsr[0]};
    end
  endtask

  // pending bit for a remote address or -1 for local memory
  function automatic int region_bit(input data_t addr);
    return addr[31] ? 2 :
           (addr[31:30] == 2'b01) ? 1 :
           (addr[31:29] == 3'b001) ? 0 : -1;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    $display("%s finished with %0d errors", cur_test, err_cnt - test_err);
  endtask

  task automatic mismatch(input string what, input data_t exp, input data_t act);
    $display("Fail %s: %s expected %h, actual %h", cur_test, what, exp, act);
    err_cnt++;
  endtask

  task automatic check_sb();
    for (int r = 0; r < reg_els; r++) begin
      if (int_sb_o[r] !== exp_int[r]) begin
        mismatch($sformatf("int_sb[%0d]", r), exp_int[r], int_sb_o[r]);
      end
      if (float_sb_o[r] !== exp_float[r]) begin
        mismatch($sformatf("float_sb[%0d]", r), exp_float[r], float_sb_o[r]);
      end
    end
  endtask

  task automatic drive_slot(input op_class_e op, input reg_addr_t rd, input reg_addr_t rs1,
                            input reg_addr_t rs2, input data_t a, input data_t b,
                            input imm_t imm);
    id_valid_i = 1'b1;
    id_op_i = op;
    id_rd_i = rd;
    id_rs1_i = rs1;
    id_rs2_i = rs2;
    id_rs1_val_i = a;
    id_rs2_val_i = b;
    id_imm_i = imm;
  endtask

  // clears at the coming edge where a float response beats fpu_done
  task automatic apply_clears();
    if (resp_valid_i && !resp_float_i) begin
      exp_int[resp_rd_i] = '0;
    end
    if (resp_valid_i && resp_float_i) begin
      exp_float[resp_rd_i] = '0;
    end else if (fpu_done_i) begin
      exp_float[fpu_done_rd_i] = '0;
    end
  endtask

  // hold the slot until it issues, then check the request and the set
  task automatic wait_issue();
    data_t addr;
    int rb;
    int n;
    logic mem;
    logic flt;
    logic long_op;
    logic exp_req;
    n = 0;
    #1;
    while ((stall_o !== 1'b0) && n < 80) begin
      next_cycle();
      n++;
    end
    if (stall_o !== 1'b0) begin
      $display("timeout in %s: the slot never stopped stalling", cur_test);
      err_cnt++;
    end
    addr = id_rs1_val_i + {{20{id_imm_i[11]}}, id_imm_i};
    rb = region_bit(addr);
    mem = (id_op_i == op_load) || (id_op_i == op_amo) || (id_op_i == op_flw);
    flt = (id_op_i == op_flw) || (id_op_i == op_fdiv) || (id_op_i == op_fsqrt);
    long_op = (id_op_i == op_idiv) || (id_op_i == op_fdiv) || (id_op_i == op_fsqrt);
    exp_req = mem && (rb >= 0) && !flush_i;
    if (remote_req_valid_o !== exp_req) begin
      mismatch("remote_req_valid_o", exp_req, remote_req_valid_o);
    end
    if (exp_req && (remote_req_addr_o !== addr)) begin
      mismatch("remote_req_addr_o", addr, remote_req_addr_o);
    end
    if (exp_req && (remote_req_float_o !== flt)) begin
      mismatch("remote_req_float_o", flt, remote_req_float_o);
    end
    if (exp_req && (remote_req_rd_o !== id_rd_i)) begin
      mismatch("remote_req_rd_o", id_rd_i, remote_req_rd_o);
    end
    if (!flush_i && (long_op || exp_req) && (flt || (id_rd_i != 0))) begin
      if (flt) begin
        exp_float[id_rd_i][long_op ? 3 : rb] = 1'b1;
      end else begin
        exp_int[id_rd_i][long_op ? 3 : rb] = 1'b1;
      end
    end
    if (!flush_i && (id_op_i == op_idiv)) begin
      exp_quot = (id_rs2_val_i == 0) ? '1 : id_rs1_val_i / id_rs2_val_i;
      exp_div_rd = id_rd_i;
    end
    apply_clears();
    next_cycle();
    id_valid_i = 1'b0;
    resp_valid_i = 1'b0;
    fpu_done_i = 1'b0;
    check_sb();
  endtask

  task automatic clear_pulse(input logic fpu, input logic flt, input reg_addr_t rd);
    resp_valid_i = ~fpu;
    resp_float_i = flt;
    resp_rd_i = rd;
    fpu_done_i = fpu;
    fpu_done_rd_i = rd;
    apply_clears();
    next_cycle();
    resp_valid_i = 1'b0;
    fpu_done_i = 1'b0;
    check_sb();
  endtask

  task automatic wait_div();
    int n;
    n = 0;
    while ((div_wb_valid_o !== 1'b1) && n < 60) begin
      next_cycle();
      n++;
    end
    if (div_wb_valid_o !== 1'b1) begin
      $display("timeout in %s: no divider writeback", cur_test);
      err_cnt++;
    end else begin
      if (div_wb_quot_o !== exp_quot) begin
        mismatch("div_wb_quot_o", exp_quot, div_wb_quot_o);
      end
      if (div_wb_rd_o !== exp_div_rd) begin
        mismatch("div_wb_rd_o", exp_div_rd, div_wb_rd_o);
      end
    end
  endtask

  task automatic retire_div();
    next_cycle();
    exp_int[exp_div_rd] = '0;
    check_sb();
    if (div_wb_valid_o !== 1'b0) begin
      mismatch("div_wb_valid_o after ack", 0, div_wb_valid_o);
    end
  endtask

  task automatic reset_state();
    begin_test("reset_state");
    check_sb();
    if (stall_o !== 1'b0) begin
      mismatch("stall_o", 0, stall_o);
    end
    if (remote_req_valid_o !== 1'b0) begin
      mismatch("remote_req_valid_o", 0, remote_req_valid_o);
    end
    if (div_wb_valid_o !== 1'b0) begin
      mismatch("div_wb_valid_o", 0, div_wb_valid_o);
    end
    end_test();
  endtask

  task automatic region_classify();
    data_t a;
    data_t rd;
    data_t imm;
    op_class_e op;
    begin_test("region_classify");
    for (int k = 0; k < 16; k++) begin
      rand_bits(32, a);
      rand_bits(5, rd);
      rand_bits(12, imm);
      // steer the top bits toward dram, global, group, local
      case (k % 4)
        0: a[31] = 1'b1;
        1: a[31:30] = 2'b01;
        2: a[31:29] = 3'b001;
        default: a[31:29] = 3'b000;
      endcase
      op = (k % 3 == 0) ? op_load : (k % 3 == 1) ? op_amo : op_flw;
      drive_slot(op, rd[4:0], 0, 0, a, 0, imm[11:0]);
      wait_issue();
      clear_pulse(1'b0, op == op_flw, rd[4:0]);
    end
    end_test();
  endtask

  task automatic hazard_stall();
    begin_test("hazard_stall");
    drive_slot(op_load, 5, 0, 0, 32'h8000_0000, 0, 0);
    wait_issue();
    // read after write on x5
    drive_slot(op_alu, 9, 5, 0, 0, 0, 0);
    for (int k = 0; k < 3; k++) begin
      #1;
      if (stall_o !== 1'b1) begin
        mismatch("stall_o on pending source", 1, stall_o);
      end
      next_cycle();
    end
    clear_pulse(1'b0, 1'b0, 5);
    wait_issue();
    // write after write on x6
    drive_slot(op_load, 6, 0, 0, 32'h4000_0000, 0, 0);
    wait_issue();
    drive_slot(op_load, 6, 0, 0, 32'h2000_0000, 0, 0);
    #1;
    if (stall_o !== 1'b1) begin
      mismatch("stall_o on pending rd", 1, stall_o);
    end
    next_cycle();
    clear_pulse(1'b0, 1'b0, 6);
    wait_issue();
    clear_pulse(1'b0, 1'b0, 6);
    end_test();
  endtask

  task automatic integer_divide();
    data_t a;
    data_t b;
    begin_test("integer_divide");
    for (int k = 0; k < 4; k++) begin
      rand_bits(32, a);
      rand_bits(32 - 8 * k, b);
      if (k == 3) begin
        b = '0;
      end
      drive_slot(op_idiv, 10 + k, 0, 0, a, b, 0);
      wait_issue();
      wait_div();
      retire_div();
    end
    drive_slot(op_idiv, 20, 0, 0, 1000, 7, 0);
    wait_issue();
    drive_slot(op_idiv, 21, 0, 0, 500, 9, 0);
    #1;
    if (stall_o !== 1'b1) begin
      mismatch("stall_o on busy divider", 1, stall_o);
    end
    wait_div();
    // integer response collides with the writeback
    resp_valid_i = 1'b1;
    resp_float_i = 1'b0;
    resp_rd_i = 3;
    apply_clears();
    next_cycle();
    resp_valid_i = 1'b0;
    check_sb();
    if (div_wb_valid_o !== 1'b1) begin
      mismatch("div_wb_valid_o after collision", 1, div_wb_valid_o);
    end
    wait_div();
    exp_int[20] = '0;
    wait_issue();
    wait_div();
    retire_div();
    end_test();
  endtask

  task automatic flush_drop();
    begin_test("flush");
    flush_i = 1'b1;
    drive_slot(op_load, 12, 0, 0, 32'h8000_0010, 0, 0);
    wait_issue();
    drive_slot(op_idiv, 13, 0, 0, 77, 5, 0);
    wait_issue();
    // an idle divider lets a new idiv through
    drive_slot(op_idiv, 14, 0, 0, 77, 5, 0);
    #1;
    if (stall_o !== 1'b0) begin
      mismatch("stall_o after flushed idiv", 0, stall_o);
    end
    next_cycle();
    flush_i = 1'b0;
    id_valid_i = 1'b0;
    end_test();
  endtask

  task automatic float_side();
    begin_test("float_side");
    drive_slot(op_fdiv, 7, 1, 2, 0, 0, 0);
    wait_issue();
    drive_slot(op_fsqrt, 8, 3, 0, 0, 0, 0);
    wait_issue();
    clear_pulse(1'b1, 1'b0, 7);
    // set and clear on f9 in the same cycle
    fpu_done_i = 1'b1;
    fpu_done_rd_i = 9;
    drive_slot(op_fsqrt, 9, 4, 0, 0, 0, 0);
    wait_issue();
    clear_pulse(1'b1, 1'b0, 8);
    end_test();
  endtask

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    flush_i = 1'b0;
    id_valid_i = 1'b0;
    id_op_i = op_nop;
    id_rd_i = '0;
    id_rs1_i = '0;
    id_rs2_i = '0;
    id_rs1_val_i = '0;
    id_rs2_val_i = '0;
    id_imm_i = '0;
    resp_valid_i = 1'b0;
    resp_float_i = 1'b0;
    resp_rd_i = '0;
    fpu_done_i = 1'b0;
    fpu_done_rd_i = '0;
    lfsr = 16'd97;
    err_cnt = 0;
    test_cnt = 0;
    for (int r = 0; r < reg_els; r++) begin
      exp_int[r] = '0;
      exp_float[r] = '0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    reset_state();
    region_classify();
    hazard_stall();
    integer_divide();
    flush_drop();
    float_side();
    $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* vanilla_sb.f */
+incdir+include
rtl/vanilla_sb_pkg.sv
rtl/sb_set_if.sv
rtl/remote_region_decoder.sv
rtl/scoreboard_tracker.sv
rtl/hazard_check.sv
rtl/idiv_unit.sv
rtl/vanilla_sb_top.sv
verif/vanilla_sb_assertions.sv
verif/tb_vanilla_sb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_vanilla_sb
FILELIST ?= vanilla_sb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
